/* flist.f */
+incdir+rtl
rtl/asg_pkg.sv
rtl/asg_if.sv
rtl/asg_ctrl.sv
rtl/asg_pointer.sv
rtl/asg_table.sv
rtl/asg_out.sv
rtl/asg_top.sv
verif/asg_tb.sv

/* rtl/asg_ctrl.sv */
////////////////////
// waveform generator control
// run/stop/trigger FSM, burst counters and slot issue
////////////////////

`timescale 1ns/10ps

module asg_ctrl import asg_pkg::*; (
  input  logic      sto,
  input  logic      ctl_rst,
  input  logic      ctl_str,
  input  logic      ctl_stp,
  input  logic      ctl_trg,
  input  logic      cfg_ben,
  input  logic      cfg_inf,
  input  asg_bln_t  cfg_bdl,
  input  asg_bln_t  cfg_bln,
  input  asg_bnm_t  cfg_bnm,
  output logic      sts_str,
  output logic      sts_trg,
  output asg_bln_t  sts_bln,
  output asg_bnm_t  sts_bnm,
  output logic      evn_per,
  output logic      ptr_load,
  output logic      ptr_adv,
  asg_slot_if.src   slot
);

  asg_state_e state;

  // run start, slot accept
  logic run;
  logic acc;
  // counter end flags
  logic end_bdl;
  logic end_bln;
  logic end_bnm;
  // burst period closes on this slot
  logic per_end;

  ////////////////////
  // decode
  ////////////////////

  // trigger counts only when started, or together with start
  // triggers while running fall through
  assign run = ctl_trg & ((state == ST_ARMED) | ((state == ST_IDLE) & ctl_str));

  assign end_bdl = (sts_bln == cfg_bdl);
  assign end_bln = (sts_bln == cfg_bln);
  assign end_bnm = (sts_bnm == cfg_bnm) & ~cfg_inf;

  // slot issue follows state directly
  assign slot.vld = (state == ST_DATA) | (state == ST_GAP);
  assign slot.cmd = (state == ST_GAP) ? CMD_HOLD : CMD_DATA;
  // counters only move on accept, so lst holds while stalled
  assign slot.lst = cfg_ben & end_bln & end_bnm;

  assign acc     = slot.vld & slot.rdy;
  assign per_end = acc & cfg_ben & end_bln;

  // pointer control
  assign ptr_load = run & ~ctl_stp;
  assign ptr_adv  = acc & (state == ST_DATA);

  // status
  assign sts_str = (state != ST_IDLE);
  assign sts_trg = slot.vld;

  ////////////////////
  // state machine
  ////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state <= ST_IDLE;
    end else if (ctl_stp) begin
      // stop wins and in-flight items drain downstream
      state <= ST_IDLE;
    end else begin
      unique case (state)
        ST_IDLE: begin
          if (run) begin
            state <= ST_DATA;
          end else if (ctl_str) begin
            state <= ST_ARMED;
          end
        end
        ST_ARMED: begin
          if (run) begin
            state <= ST_DATA;
          end
        end
        ST_DATA, ST_GAP: begin
          if (acc & cfg_ben) begin
            if (end_bln) begin
              // next period or done
              state <= end_bnm ? ST_IDLE : ST_DATA;
            end else if ((state == ST_DATA) & end_bdl) begin
              state <= ST_GAP;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // burst counters
  ////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_bln <= '0;
      sts_bnm <= '0;
      evn_per <= 1'b0;
    end else begin
      evn_per <= per_end;
      if (run) begin
        sts_bln <= '0;
        sts_bnm <= '0;
      end else if (acc & cfg_ben) begin
        if (end_bln) begin
          sts_bln <= '0;
          // final period leaves the count at cfg_bnm
          if (!end_bnm) begin
            sts_bnm <= sts_bnm + 1'b1;
          end
        end else begin
          sts_bln <= sts_bln + 1'b1;
        end
      end
    end
  end

  // nothing issued before the trigger
  a_slot_idle: assert property (@(posedge sto) disable iff (ctl_rst)
    $past(state inside {ST_IDLE, ST_ARMED}) && !$past(ptr_load) |-> !slot.vld);

endmodule

/* rtl/asg_defs.svh */
////////////////////
// waveform generator widths
// table depth, fixed point format and burst counter sizes
////////////////////

`ifndef ASG_DEFS_SVH
`define ASG_DEFS_SVH

// pointer integer part
// table holds 2**ASG_CWM samples
`define ASG_CWM 8

// pointer fraction part
`define ASG_CWF 8

// signed DAC sample width
`define ASG_DW 14

// burst length counter
`define ASG_CWL 16

// burst repetition counter
`define ASG_CWN 8

`endif

/* rtl/asg_if.sv */
////////////////////
// waveform generator internal links
// slot command hop and sample hop, both valid/ready
////////////////////

`timescale 1ns/10ps

// slot from controller to table
interface asg_slot_if import asg_pkg::*; ();

  logic     vld;
  logic     rdy;
  asg_cmd_e cmd;
  // slot closes the final period
  logic     lst;

  modport src (
    output vld, cmd, lst,
    input  rdy
  );

  modport dst (
    input  vld, cmd, lst,
    output rdy
  );

endinterface

// sample from table to output register
interface asg_smp_if import asg_pkg::*; ();

  logic        vld;
  logic        rdy;
  asg_sample_t data;
  logic        lst;

  modport src (
    output vld, data, lst,
    input  rdy
  );

  modport dst (
    input  vld, data, lst,
    output rdy
  );

endinterface

/* rtl/asg_out.sv */
////////////////////
// waveform generator output register
////////////////////

`timescale 1ns/10ps

module asg_out import asg_pkg::*; (
  input  logic        sto,
  input  logic        ctl_rst,
  asg_smp_if.dst      smp,
  output asg_sample_t out_data,
  output logic        out_valid,
  output logic        out_last,
  input  logic        out_ready,
  output logic        evn_lst
);

  // register empty or draining
  assign smp.rdy = out_ready | ~out_valid;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (smp.rdy) begin
      out_valid <= smp.vld;
      // last only ever seen with valid
      out_last  <= smp.vld & smp.lst;
    end
  end

  always_ff @(posedge sto) begin
    if (smp.vld & smp.rdy) begin
      out_data <= smp.data;
    end
  end

  // pulse after the last sample leaves
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      evn_lst <= 1'b0;
    end else begin
      evn_lst <= out_valid & out_ready & out_last;
    end
  end

  // stream hold under back-pressure
  a_out_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

/* rtl/asg_pkg.sv */
////////////////////
// waveform generator types
// controller states, slot commands and data types
////////////////////

`include "asg_defs.svh"

package asg_pkg;

  // controller state
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    // started, waiting for trigger
    ST_ARMED = 2'd1,
    // reading the table
    ST_DATA  = 2'd2,
    // idle part of a burst period
    ST_GAP   = 2'd3
  } asg_state_e;

  // slot command
  typedef enum logic {
    // read table at pointer
    CMD_DATA = 1'b0,
    // repeat last sample
    CMD_HOLD = 1'b1
  } asg_cmd_e;

  typedef logic signed [`ASG_DW-1:0]       asg_sample_t;
  // fixed point, integer over fraction
  typedef logic [`ASG_CWM+`ASG_CWF-1:0]    asg_ptr_t;
  typedef logic [`ASG_CWM-1:0]             asg_addr_t;
  typedef logic [`ASG_CWL-1:0]             asg_bln_t;
  typedef logic [`ASG_CWN-1:0]             asg_bnm_t;

endpackage

/* rtl/asg_pointer.sv */
////////////////////
// waveform generator phase pointer
// fixed point accumulator with modulo table wrap
////////////////////

`timescale 1ns/10ps

`include "asg_defs.svh"

module asg_pointer import asg_pkg::*; (
  input  logic      sto,
  input  logic      ctl_rst,
  input  logic      ptr_load,
  input  logic      ptr_adv,
  input  asg_ptr_t  cfg_siz,
  input  asg_ptr_t  cfg_ste,
  input  asg_ptr_t  cfg_off,
  output asg_addr_t addr
);

  asg_ptr_t ptr;

  // one extra bit for carry and borrow
  logic [`ASG_CWM+`ASG_CWF:0] siz_len;
  logic [`ASG_CWM+`ASG_CWF:0] ptr_nxt;
  logic [`ASG_CWM+`ASG_CWF:0] ptr_sub;
  logic                       ptr_wrap;

  // table length and stepped pointer
  assign siz_len = {1'b0, cfg_siz} + 1'b1;
  assign ptr_nxt = {1'b0, ptr} + {1'b0, cfg_ste} + 1'b1;
  assign ptr_sub = ptr_nxt - siz_len;
  // borrow clear means sum reached table length
  assign ptr_wrap = ~ptr_sub[`ASG_CWM+`ASG_CWF];

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr <= '0;
    end else if (ptr_load) begin
      ptr <= cfg_off;
    end else if (ptr_adv) begin
      ptr <= ptr_wrap ? ptr_sub[`ASG_CWM+`ASG_CWF-1:0] : ptr_nxt[`ASG_CWM+`ASG_CWF-1:0];
    end
  end

  // table index is the integer part
  assign addr = ptr[`ASG_CWF +: `ASG_CWM];

  // wrap keeps the pointer inside the table
  a_ptr_range: assert property (@(posedge sto) disable iff (ctl_rst)
    $past(ptr_adv) && !$past(ptr_load) |-> ({1'b0, ptr} < siz_len));

endmodule

/* rtl/asg_table.sv */
////////////////////
// waveform generator sample table
// host write/read port and stream read stage
////////////////////

`timescale 1ns/10ps

`include "asg_defs.svh"

module asg_table import asg_pkg::*; (
  input  logic        sto,
  input  logic        ctl_rst,
  input  logic        tbl_wen,
  input  logic        tbl_ren,
  input  asg_addr_t   tbl_addr,
  input  asg_sample_t tbl_wdata,
  output asg_sample_t tbl_rdata,
  output logic        tbl_ack,
  input  asg_addr_t   addr,
  asg_slot_if.dst     slot,
  asg_smp_if.src      smp
);

  asg_sample_t mem [0:2**`ASG_CWM-1];

  logic slot_acc;

  ////////////////////
  // host port
  ////////////////////

  always_ff @(posedge sto) begin
    if (tbl_wen) begin
      mem[tbl_addr] <= tbl_wdata;
    end
    if (tbl_ren) begin
      tbl_rdata <= mem[tbl_addr];
    end
  end

  // ack lines up with rdata
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      tbl_ack <= 1'b0;
    end else begin
      tbl_ack <= tbl_wen | tbl_ren;
    end
  end

  ////////////////////
  // stream read
  ////////////////////

  // free when empty or when the held sample leaves
  assign slot.rdy = smp.rdy | ~smp.vld;
  assign slot_acc = slot.vld & slot.rdy;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      smp.vld <= 1'b0;
    end else if (slot.rdy) begin
      smp.vld <= slot.vld;
    end
  end

  // payload
  always_ff @(posedge sto) begin
    if (slot_acc) begin
      smp.lst <= slot.lst;
      // hold slot keeps previous sample
      if (slot.cmd == CMD_DATA) begin
        smp.data <= mem[addr];
      end
    end
  end

endmodule

/* rtl/asg_top.sv */
////////////////////
// arbitrary waveform generator
// one channel, sample table streamed to a DAC under valid/ready
////////////////////

`timescale 1ns/10ps

module asg_top import asg_pkg::*; (
  input  logic        sto,
  input  logic        ctl_rst,
  // control and status
  input  logic        ctl_str,
  input  logic        ctl_stp,
  input  logic        ctl_trg,
  output logic        sts_str,
  output logic        sts_trg,
  output asg_bln_t    sts_bln,
  output asg_bnm_t    sts_bnm,
  // periodic mode
  input  asg_ptr_t    cfg_siz,
  input  asg_ptr_t    cfg_ste,
  input  asg_ptr_t    cfg_off,
  // burst mode
  input  logic        cfg_ben,
  input  logic        cfg_inf,
  input  asg_bln_t    cfg_bdl,
  input  asg_bln_t    cfg_bln,
  input  asg_bnm_t    cfg_bnm,
  // host table port
  input  logic        tbl_wen,
  input  logic        tbl_ren,
  input  asg_addr_t   tbl_addr,
  input  asg_sample_t tbl_wdata,
  output asg_sample_t tbl_rdata,
  output logic        tbl_ack,
  // sample stream
  output asg_sample_t out_data,
  output logic        out_valid,
  output logic        out_last,
  input  logic        out_ready,
  // events
  output logic        evn_per,
  output logic        evn_lst
);

  logic      ptr_load;
  logic      ptr_adv;
  asg_addr_t ptr_addr;

  asg_slot_if slot_if ();
  asg_smp_if  smp_if ();

  ////////////////////
  // control and pointer
  ////////////////////

  asg_ctrl u_ctrl (
    .sto      (sto),
    .ctl_rst  (ctl_rst),
    .ctl_str  (ctl_str),
    .ctl_stp  (ctl_stp),
    .ctl_trg  (ctl_trg),
    .cfg_ben  (cfg_ben),
    .cfg_inf  (cfg_inf),
    .cfg_bdl  (cfg_bdl),
    .cfg_bln  (cfg_bln),
    .cfg_bnm  (cfg_bnm),
    .sts_str  (sts_str),
    .sts_trg  (sts_trg),
    .sts_bln  (sts_bln),
    .sts_bnm  (sts_bnm),
    .evn_per  (evn_per),
    .ptr_load (ptr_load),
    .ptr_adv  (ptr_adv),
    .slot     (slot_if.src)
  );

  asg_pointer u_pointer (
    .sto      (sto),
    .ctl_rst  (ctl_rst),
    .ptr_load (ptr_load),
    .ptr_adv  (ptr_adv),
    .cfg_siz  (cfg_siz),
    .cfg_ste  (cfg_ste),
    .cfg_off  (cfg_off),
    .addr     (ptr_addr)
  );

  ////////////////////
  // table and output
  ////////////////////

  asg_table u_table (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .tbl_wen   (tbl_wen),
    .tbl_ren   (tbl_ren),
    .tbl_addr  (tbl_addr),
    .tbl_wdata (tbl_wdata),
    .tbl_rdata (tbl_rdata),
    .tbl_ack   (tbl_ack),
    .addr      (ptr_addr),
    .slot      (slot_if.dst),
    .smp       (smp_if.src)
  );

  asg_out u_out (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .smp       (smp_if.dst),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready),
    .evn_lst   (evn_lst)
  );

endmodule

/* run.sh */
#!/bin/sh
# build and run the waveform generator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f flist.f \
  --top-module asg_tb \
  -o asg_sim

./obj_dir/asg_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  exit 0
else
  echo "simulation did not report a pass, see sim.log"
  exit 1
fi

/* verif/asg_tb.sv */
////////////////////
// waveform generator testbench
// host port, periodic, offset, burst and back-pressure runs
////////////////////

`timescale 1ns/10ps

`include "asg_defs.svh"

module asg_tb import asg_pkg::*; ();

  localparam int NT    = 6;
  localparam int DEPTH = 2**`ASG_CWM;

  // one test row
  typedef struct packed {
    asg_ptr_t    siz;
    asg_ptr_t    ste;
    asg_ptr_t    off;
    logic        ben;
    logic        inf;
    asg_bln_t    bdl;
    asg_bln_t    bln;
    asg_bnm_t    bnm;
    logic [15:0] nsmp;
    logic        rnd;
  } row_t;

  logic        sto;
  logic        ctl_rst;
  logic        ctl_str;
  logic        ctl_stp;
  logic        ctl_trg;
  logic        sts_str;
  logic        sts_trg;
  asg_bln_t    sts_bln;
  asg_bnm_t    sts_bnm;
  asg_ptr_t    cfg_siz;
  asg_ptr_t    cfg_ste;
  asg_ptr_t    cfg_off;
  logic        cfg_ben;
  logic        cfg_inf;
  asg_bln_t    cfg_bdl;
  asg_bln_t    cfg_bln;
  asg_bnm_t    cfg_bnm;
  logic        tbl_wen;
  logic        tbl_ren;
  asg_addr_t   tbl_addr;
  asg_sample_t tbl_wdata;
  asg_sample_t tbl_rdata;
  logic        tbl_ack;
  asg_sample_t out_data;
  logic        out_valid;
  logic        out_last;
  logic        out_ready;
  logic        evn_per;
  logic        evn_lst;

  row_t        rows [0:NT-1];
  string       names [0:NT-1];
  asg_sample_t wave [0:DEPTH-1];
  asg_sample_t expq [$];
  logic [31:0] rng = 32'hced9;

  int errs = 0;
  int checks = 0;
  int tests = 0;
  int cycles = 0;
  int limit = 1000000;
  // collection state shared by the run tasks
  int idx;
  int it;
  int lat;
  int n_per;
  int n_lst;
  int total;
  bit fin;

  asg_top uut (.*);

  always #4 sto = ~sto;

  // run limit
  always @(posedge sto) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng;
  endfunction

  // pointer advance with table wrap
  function automatic int ptr_step(input int p, input int stp, input int len);
    int s;
    s = p + stp;
    if (s >= len) s = s - len;
    return s;
  endfunction

  task automatic check_sample(input string sig, input asg_sample_t got, input asg_sample_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("FAILED t=%0t %s got %0d expected %0d", $time, sig, got, exp);
    end
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("FAILED t=%0t %s got %b expected %b", $time, sig, got, exp);
    end
  endtask

  task automatic check_count(input string sig, input asg_bnm_t got, input asg_bnm_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("FAILED t=%0t %s got %0d expected %0d", $time, sig, got, exp);
    end
  endtask

  task automatic check_length(input string sig, input asg_bln_t got, input asg_bln_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("FAILED t=%0t %s got %0d expected %0d", $time, sig, got, exp);
    end
  endtask

  task automatic set_row(input int r, input string nm, input asg_ptr_t siz, input asg_ptr_t ste,
                         input asg_ptr_t off, input logic ben, input logic inf,
                         input asg_bln_t bdl, input asg_bln_t bln, input asg_bnm_t bnm,
                         input int nsmp, input logic rnd);
    names[r] = nm;
    rows[r]  = '{siz, ste, off, ben, inf, bdl, bln, bnm, nsmp[15:0], rnd};
  endtask

  ////////////////////
  // reference model
  ////////////////////

  task automatic build_model(input int r);
    int p;
    int len;
    int stp;
    int j;
    int per;
    asg_sample_t held;
    expq.delete();
    p    = int'(rows[r].off);
    len  = int'(rows[r].siz) + 1;
    stp  = int'(rows[r].ste) + 1;
    held = '0;
    per  = 0;
    if (!rows[r].ben) begin
      // plain periodic with margin for samples still in flight at stop
      while (expq.size() < rows[r].nsmp + 8) begin
        expq.push_back(wave[(p >> `ASG_CWF) % DEPTH]);
        p = ptr_step(p, stp, len);
      end
    end else begin
      while (rows[r].inf ? (expq.size() < rows[r].nsmp + 8) : (per <= int'(rows[r].bnm))) begin
        for (j = 0; j <= int'(rows[r].bln); j++) begin
          // data part reads the table, idle part repeats
          if (j <= int'(rows[r].bdl)) begin
            held = wave[(p >> `ASG_CWF) % DEPTH];
            p = ptr_step(p, stp, len);
          end
          expq.push_back(held);
        end
        per++;
      end
    end
  endtask

  ////////////////////
  // reset values
  ////////////////////

  task automatic reset_test();
    int err0;
    err0 = errs;
    @(negedge sto);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("out_last", out_last, 1'b0);
    check_flag("sts_str", sts_str, 1'b0);
    check_flag("sts_trg", sts_trg, 1'b0);
    check_flag("evn_per", evn_per, 1'b0);
    check_flag("evn_lst", evn_lst, 1'b0);
    check_flag("tbl_ack", tbl_ack, 1'b0);
    check_length("sts_bln", sts_bln, '0);
    check_count("sts_bnm", sts_bnm, '0);
    @(posedge sto);
    #1;
    tests++;
    $display("test reset: %0d errors", errs - err0);
  endtask

  ////////////////////
  // host port
  ////////////////////

  // pipelined access with ack and rdata one cycle behind
  task automatic host_pass(input bit rd);
    int k;
    for (k = 0; k <= DEPTH; k++) begin
      tbl_wen  = !rd && (k < DEPTH);
      tbl_ren  = rd && (k < DEPTH);
      tbl_addr = asg_addr_t'(k);
      tbl_wdata = (k < DEPTH) ? wave[k] : '0;
      @(negedge sto);
      if (k > 0) begin
        check_flag("tbl_ack", tbl_ack, 1'b1);
        if (rd) check_sample("tbl_rdata", tbl_rdata, wave[k-1]);
      end
      @(posedge sto);
      #1;
    end
    tbl_wen = 1'b0;
    tbl_ren = 1'b0;
    @(negedge sto);
    check_flag("tbl_ack", tbl_ack, 1'b0);
    @(posedge sto);
    #1;
  endtask

  ////////////////////
  // control
  ////////////////////

  task automatic control_test();
    int err0;
    err0 = errs;
    // trigger while idle and never started
    ctl_trg = 1'b1;
    @(posedge sto);
    #1;
    ctl_trg = 1'b0;
    repeat (12) begin
      @(negedge sto);
      check_flag("out_valid", out_valid, 1'b0);
      @(posedge sto);
      #1;
    end
    check_flag("sts_str", sts_str, 1'b0);
    ctl_str = 1'b1;
    @(posedge sto);
    #1;
    ctl_str = 1'b0;
    check_flag("sts_str", sts_str, 1'b1);
    ctl_stp = 1'b1;
    @(posedge sto);
    #1;
    ctl_stp = 1'b0;
    check_flag("sts_str", sts_str, 1'b0);
    tests++;
    $display("test control: %0d errors", errs - err0);
  endtask

  ////////////////////
  // stream runs
  ////////////////////

  // one negedge observation of the stream
  task automatic observe_out();
    if (out_valid && lat < 0) lat = it;
    if (evn_per) n_per++;
    if (evn_lst) n_lst++;
    if (out_valid && out_ready) begin
      if (idx < expq.size()) begin
        check_sample("out_data", out_data, expq[idx]);
        check_flag("out_last", out_last, fin && (idx == total - 1));
      end else begin
        errs++;
        $display("sample at %0t arrived beyond the expected sequence", $time);
      end
      idx++;
    end
    it++;
  endtask

  task automatic run_test(input int r);
    int err0;
    bit stopped;
    bit retrig;
    logic [31:0] rv;
    err0 = errs;
    build_model(r);
    fin   = rows[r].ben && !rows[r].inf;
    total = fin ? expq.size() : int'(rows[r].nsmp);
    idx   = 0;
    it    = 0;
    lat   = -1;
    n_per = 0;
    n_lst = 0;
    stopped = 1'b0;
    retrig  = 1'b0;
    cfg_siz = rows[r].siz;
    cfg_ste = rows[r].ste;
    cfg_off = rows[r].off;
    cfg_ben = rows[r].ben;
    cfg_inf = rows[r].inf;
    cfg_bdl = rows[r].bdl;
    cfg_bln = rows[r].bln;
    cfg_bnm = rows[r].bnm;
    ctl_str = 1'b1;
    @(posedge sto);
    #1;
    ctl_str = 1'b0;
    ctl_trg = 1'b1;
    while (fin ? (idx < total) : !stopped) begin
      @(negedge sto);
      observe_out();
      @(posedge sto);
      #1;
      ctl_trg = 1'b0;
      ctl_stp = 1'b0;
      // trigger in the middle of a run
      if (!retrig && idx >= 5) begin
        ctl_trg = 1'b1;
        retrig  = 1'b1;
      end
      rv = lcg_next();
      out_ready = rows[r].rnd ? rv[22] : 1'b1;
      if (!fin && idx >= total) begin
        ctl_stp = 1'b1;
        stopped = 1'b1;
        out_ready = 1'b1;
      end
    end
    // drain what is still in flight
    repeat (8) begin
      @(negedge sto);
      observe_out();
      @(posedge sto);
      #1;
      ctl_trg = 1'b0;
      ctl_stp = 1'b0;
      out_ready = 1'b1;
    end
    if (lat < 0) begin
      errs++;
      $display("no output sample appeared in test %s", names[r]);
    end else begin
      check_count("first_valid_latency", asg_bnm_t'(lat), 8'd3);
    end
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("sts_trg", sts_trg, 1'b0);
    if (fin) begin
      check_count("evn_per_count", asg_bnm_t'(n_per), rows[r].bnm + 8'd1);
      check_count("sts_bnm", sts_bnm, rows[r].bnm);
      // last period end clears the length counter
      check_length("sts_bln", sts_bln, '0);
      check_count("evn_lst_count", asg_bnm_t'(n_lst), 8'd1);
    end else begin
      check_count("evn_lst_count", asg_bnm_t'(n_lst), 8'd0);
      check_flag("sts_str", sts_str, 1'b0);
      if (!rows[r].ben) check_count("evn_per_count", asg_bnm_t'(n_per), 8'd0);
    end
    tests++;
    $display("test %s: %0d samples, %0d errors", names[r], idx, errs - err0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int r;
    int sum;
    int err0;
    sto       = 1'b0;
    ctl_rst   = 1'b1;
    ctl_str   = 1'b0;
    ctl_stp   = 1'b0;
    ctl_trg   = 1'b0;
    cfg_siz   = '0;
    cfg_ste   = '0;
    cfg_off   = '0;
    cfg_ben   = 1'b0;
    cfg_inf   = 1'b0;
    cfg_bdl   = '0;
    cfg_bln   = '0;
    cfg_bnm   = '0;
    tbl_wen   = 1'b0;
    tbl_ren   = 1'b0;
    tbl_addr  = '0;
    tbl_wdata = '0;
    out_ready = 1'b1;

    // name, siz, ste, off, ben, inf, bdl, bln, bnm, samples, random ready
    set_row(0, "periodic", 16'hC7FF, 16'h017F, 16'h0000, 0, 0, 0, 0, 0, 300, 0);
    set_row(1, "phase", 16'hC7FF, 16'h017F, 16'h3A80, 0, 0, 0, 0, 0, 200, 0);
    set_row(2, "burst", 16'hFFFF, 16'h00FF, 16'h1000, 1, 0, 5, 11, 3, 48, 0);
    set_row(3, "backpressure", 16'h63FF, 16'h0233, 16'h0500, 1, 0, 6, 9, 7, 80, 1);
    set_row(4, "periodic_rnd", 16'h7FFF, 16'h0C0F, 16'h0000, 0, 0, 0, 0, 0, 150, 1);
    set_row(5, "burst_inf", 16'hFFFF, 16'h02FF, 16'h2000, 1, 1, 2, 4, 0, 60, 1);

    // four cycles per sample plus reset, table load and per test overhead
    sum = 0;
    for (r = 0; r < NT; r++) sum += int'(rows[r].nsmp);
    limit = sum * 4 + 16 + 2 * (DEPTH + 2) + 32 * NT + 64;

    // waveform content
    for (r = 0; r < DEPTH; r++) wave[r] = asg_sample_t'(lcg_next() >> 16);

    repeat (16) @(posedge sto);
    #1;
    ctl_rst = 1'b0;

    reset_test();

    err0 = errs;
    host_pass(1'b0);
    host_pass(1'b1);
    tests++;
    $display("test host_port: %0d errors", errs - err0);

    control_test();
    for (r = 0; r < NT; r++) run_test(r);

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errs);
    if (errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
